/* design/wbuf_cfg_pkg.sv */
// store buffer sizing
// word width, physical address split and entry count shared by the
// core store port and the entry storage

package wbuf_cfg_pkg;

  ////////////////////
  // core word
  ////////////////////

  // one store is one 64-bit word with byte enables
  localparam int XLEN = 64;
  localparam int NUM_BYTES = XLEN / 8;
  // byte offset inside a word
  localparam int BYTE_OFF_W = $clog2(NUM_BYTES);

  ////////////////////
  // addressing
  ////////////////////

  localparam int PLEN = 32;
  // entries are keyed by word address, offset bits dropped
  localparam int WTAG_W = PLEN - BYTE_OFF_W;

  ////////////////////
  // buffer
  ////////////////////

  // fully associative, so every entry is compared on each store
  localparam int WBUF_DEPTH = 4;
  localparam int WBUF_PTR_W = $clog2(WBUF_DEPTH);

endpackage

/* design/wbuf_mem_pkg.sv */
// memory transaction definitions for the store buffer
// size codes, transaction ID sizing and the memory address view

package wbuf_mem_pkg;

  ////////////////////
  // transaction IDs
  ////////////////////

  // transactions in flight, each with its own ID
  localparam int MAX_TX = 2;
  localparam int TX_ID_W = $clog2(MAX_TX);

  ////////////////////
  // size codes
  ////////////////////

  // naturally aligned chunks only, the memory has no byte enables
  localparam int SIZE_W = 2;
  localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
  localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
  localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;
  localparam logic [SIZE_W-1:0] SIZE_DWORD = 2'd3;

  ////////////////////
  // address view
  ////////////////////

  // flat physical address, or word address plus byte offset
  typedef union packed {
    logic [wbuf_cfg_pkg::PLEN-1:0] flat;
    struct packed {
      logic [wbuf_cfg_pkg::WTAG_W-1:0] wtag;
      logic [wbuf_cfg_pkg::BYTE_OFF_W-1:0] off;
    } split;
  } mem_addr_u;

endpackage

/* design/wbuf_store.sv */
// store buffer entry storage
// word address, data and per-byte valid/dirty/tx-block bits per entry
// byte states: 000 free, 110 dirty, 101 in flight,
// 111 overwritten while in flight and sent again later

`timescale 1ns/1ps

module wbuf_store (
  input  logic                                                          clk_i,
  input  logic                                                          rst_i,
  // store write
  input  logic                                                          wr_en_i,
  input  logic [wbuf_cfg_pkg::WBUF_PTR_W-1:0]                           wr_ptr_i,
  input  logic [wbuf_cfg_pkg::WTAG_W-1:0]                               wr_wtag_i,
  input  logic [wbuf_cfg_pkg::NUM_BYTES-1:0]                            wr_be_i,
  input  logic [wbuf_cfg_pkg::XLEN-1:0]                                 wr_data_i,
  // transaction taken by memory
  input  logic                                                          sent_i,
  input  logic [wbuf_cfg_pkg::WBUF_PTR_W-1:0]                           sent_ptr_i,
  input  logic [wbuf_cfg_pkg::NUM_BYTES-1:0]                            sent_mask_i,
  // write response returned
  input  logic                                                          evict_i,
  input  logic [wbuf_cfg_pkg::WBUF_PTR_W-1:0]                           evict_ptr_i,
  input  logic [wbuf_cfg_pkg::NUM_BYTES-1:0]                            evict_mask_i,
  // entry state
  output logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0]                           entry_valid_o,
  output logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0][wbuf_cfg_pkg::WTAG_W-1:0] entry_wtag_o,
  output logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0][wbuf_cfg_pkg::XLEN-1:0]   entry_data_o,
  output logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0][wbuf_cfg_pkg::NUM_BYTES-1:0] sendable_o,
  output logic                                                          empty_o
);

  import wbuf_cfg_pkg::*;

  logic [WBUF_DEPTH-1:0][NUM_BYTES-1:0] valid_q;
  logic [WBUF_DEPTH-1:0][NUM_BYTES-1:0] dirty_q;
  logic [WBUF_DEPTH-1:0][NUM_BYTES-1:0] txblock_q;
  logic [WBUF_DEPTH-1:0][WTAG_W-1:0]    wtag_q;
  logic [WBUF_DEPTH-1:0][XLEN-1:0]      data_q;

  ////////////////////
  // state readout
  ////////////////////

  always_comb begin
    for (int k = 0; k < WBUF_DEPTH; k++) begin
      entry_valid_o[k] = |valid_q[k];
      // hold back the whole word while any byte is in flight
      // so two transactions to one word never overtake each other
      sendable_o[k] = (|txblock_q[k]) ? '0 : (dirty_q[k] & valid_q[k]);
    end
  end

  assign entry_wtag_o = wtag_q;
  assign entry_data_o = data_q;
  assign empty_o      = ~|entry_valid_o;

  ////////////////////
  // byte states
  ////////////////////

  // evict, sent, write in that order, so the write wins
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q   <= '0;
      dirty_q   <= '0;
      txblock_q <= '0;
    end else begin
      for (int b = 0; b < NUM_BYTES; b++) begin
        // response back, free the byte unless rewritten meanwhile
        if (evict_i && evict_mask_i[b]) begin
          txblock_q[evict_ptr_i][b] <= 1'b0;
          if (!dirty_q[evict_ptr_i][b]) begin
            valid_q[evict_ptr_i][b] <= 1'b0;
          end
        end
        // byte now in flight
        if (sent_i && sent_mask_i[b]) begin
          dirty_q[sent_ptr_i][b]   <= 1'b0;
          txblock_q[sent_ptr_i][b] <= 1'b1;
        end
        // new store data, tx-block is left alone
        if (wr_en_i && wr_be_i[b]) begin
          valid_q[wr_ptr_i][b] <= 1'b1;
          dirty_q[wr_ptr_i][b] <= 1'b1;
        end
      end
    end
  end

  ////////////////////
  // payload
  ////////////////////

  // on a hit the word address is rewritten with the same value
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      wtag_q[wr_ptr_i] <= wr_wtag_i;
      for (int b = 0; b < NUM_BYTES; b++) begin
        if (wr_be_i[b]) begin
          data_q[wr_ptr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* design/wbuf_tx_issue.sv */
// store buffer transaction issue
// round-robin pick of an entry with sendable bytes, then one naturally
// aligned 1/2/4/8 byte transaction from its lowest sendable byte

`timescale 1ns/1ps

module wbuf_tx_issue (
  input  logic                                                          clk_i,
  input  logic                                                          rst_i,
  input  logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0][wbuf_cfg_pkg::NUM_BYTES-1:0] sendable_i,
  input  logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0][wbuf_cfg_pkg::WTAG_W-1:0] entry_wtag_i,
  input  logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0][wbuf_cfg_pkg::XLEN-1:0]   entry_data_i,
  input  logic                                                          slot_free_i,
  input  logic                                                          mem_ack_i,
  output logic                                                          mem_req_o,
  output logic [wbuf_cfg_pkg::PLEN-1:0]                                 mem_addr_o,
  output logic [wbuf_mem_pkg::SIZE_W-1:0]                               mem_size_o,
  output logic [wbuf_cfg_pkg::XLEN-1:0]                                 mem_wdata_o,
  output logic                                                          sent_o,
  output logic [wbuf_cfg_pkg::WBUF_PTR_W-1:0]                           sent_ptr_o,
  output logic [wbuf_cfg_pkg::NUM_BYTES-1:0]                            sent_mask_o
);

  import wbuf_cfg_pkg::*;
  import wbuf_mem_pkg::*;

  logic [WBUF_PTR_W-1:0] rr_q;
  logic [WBUF_PTR_W-1:0] arb_ptr;
  logic [WBUF_PTR_W-1:0] lock_ptr_q;
  logic [WBUF_PTR_W-1:0] ptr;
  logic                  lock_q;
  logic [NUM_BYTES-1:0]  bmask;
  logic [NUM_BYTES-1:0]  shifted;
  logic [NUM_BYTES-1:0]  chunk;
  logic [BYTE_OFF_W-1:0] off;
  logic [BYTE_OFF_W+2:0] bit_off;
  logic [XLEN-1:0]       data;
  mem_addr_u             addr;

  ////////////////////
  // entry arbitration
  ////////////////////

  // first entry with sendable bytes, starting at the round-robin pointer
  always_comb begin
    logic [WBUF_PTR_W-1:0] idx;
    logic                  found;
    arb_ptr = rr_q;
    found   = 1'b0;
    for (int i = 0; i < WBUF_DEPTH; i++) begin
      idx = rr_q + WBUF_PTR_W'(i);
      if (!found && (|sendable_i[idx])) begin
        found   = 1'b1;
        arb_ptr = idx;
      end
    end
  end

  // hold the choice while memory stalls
  assign ptr   = lock_q ? lock_ptr_q : arb_ptr;
  assign bmask = sendable_i[ptr];
  assign data  = entry_data_i[ptr];

  ////////////////////
  // offset and size
  ////////////////////

  // lowest sendable byte
  always_comb begin
    off = '0;
    for (int b = NUM_BYTES - 1; b >= 0; b--) begin
      if (bmask[b]) begin
        off = BYTE_OFF_W'(b);
      end
    end
  end

  // bit 0 of shifted is the offset byte itself
  assign shifted = bmask >> off;
  assign bit_off = {off, 3'b000};

  // largest aligned chunk fully made of sendable bytes
  always_comb begin
    if (&bmask) begin
      mem_size_o = SIZE_DWORD;
    end else if ((off[1:0] == 2'b00) && (&shifted[3:0])) begin
      mem_size_o = SIZE_WORD;
    end else if (!off[0] && (&shifted[1:0])) begin
      mem_size_o = SIZE_HALF;
    end else begin
      mem_size_o = SIZE_BYTE;
    end
  end

  // byte mask of the chunk, and its data replicated over the bus
  always_comb begin
    case (mem_size_o)
      SIZE_BYTE: begin
        chunk       = 8'h01;
        mem_wdata_o = {8{data[bit_off +: 8]}};
      end
      SIZE_HALF: begin
        chunk       = 8'h03;
        mem_wdata_o = {4{data[bit_off +: 16]}};
      end
      SIZE_WORD: begin
        chunk       = 8'h0f;
        mem_wdata_o = {2{data[bit_off +: 32]}};
      end
      default: begin
        chunk       = 8'hff;
        mem_wdata_o = data;
      end
    endcase
  end

  // word address plus offset, sent out flat
  always_comb begin
    addr.split.wtag = entry_wtag_i[ptr];
    addr.split.off  = off;
  end

  assign mem_addr_o = addr.flat;

  ////////////////////
  // handshake
  ////////////////////

  assign mem_req_o   = (|bmask) && slot_free_i;
  assign sent_o      = mem_req_o && mem_ack_i;
  assign sent_ptr_o  = ptr;
  assign sent_mask_o = chunk << off;

  // pointer moves past the served entry once the transaction is taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else if (sent_o) begin
      rr_q   <= ptr + 1'b1;
      lock_q <= 1'b0;
    end else if (mem_req_o) begin
      lock_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_req_o && !lock_q) begin
      lock_ptr_q <= arb_ptr;
    end
  end

endmodule

/* design/wbuf_tx_track.sv */
// store buffer transaction tracking
// one slot per transaction ID with entry pointer and byte mask, and a
// FIFO of returned IDs that drives one eviction per cycle

`timescale 1ns/1ps

module wbuf_tx_track (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 sent_i,
  input  logic [wbuf_cfg_pkg::WBUF_PTR_W-1:0]  sent_ptr_i,
  input  logic [wbuf_cfg_pkg::NUM_BYTES-1:0]   sent_mask_i,
  input  logic                                 rsp_vld_i,
  input  logic [wbuf_mem_pkg::TX_ID_W-1:0]     rsp_id_i,
  output logic [wbuf_mem_pkg::TX_ID_W-1:0]     mem_id_o,
  output logic                                 slot_free_o,
  output logic                                 evict_o,
  output logic [wbuf_cfg_pkg::WBUF_PTR_W-1:0]  evict_ptr_o,
  output logic [wbuf_cfg_pkg::NUM_BYTES-1:0]   evict_mask_o
);

  import wbuf_cfg_pkg::*;
  import wbuf_mem_pkg::*;

  logic [MAX_TX-1:0]                  slot_vld_q;
  logic [MAX_TX-1:0][WBUF_PTR_W-1:0]  slot_ptr_q;
  logic [MAX_TX-1:0][NUM_BYTES-1:0]   slot_mask_q;
  // returned IDs, MAX_TX deep so it never overflows
  logic [MAX_TX-1:0][TX_ID_W-1:0]     fifo_q;
  logic [TX_ID_W-1:0]                 wr_idx_q;
  logic [TX_ID_W-1:0]                 rd_idx_q;
  logic [TX_ID_W:0]                   cnt_q;
  logic [TX_ID_W-1:0]                 rtrn_id;

  ////////////////////
  // ID allocation
  ////////////////////

  // lowest free ID
  always_comb begin
    mem_id_o = '0;
    for (int i = MAX_TX - 1; i >= 0; i--) begin
      if (!slot_vld_q[i]) begin
        mem_id_o = TX_ID_W'(i);
      end
    end
  end

  assign slot_free_o = ~&slot_vld_q;

  ////////////////////
  // returned IDs
  ////////////////////

  // registered head, so evict lags the response by one cycle
  assign evict_o      = (cnt_q != '0);
  assign rtrn_id      = fifo_q[rd_idx_q];
  assign evict_ptr_o  = slot_ptr_q[rtrn_id];
  assign evict_mask_o = slot_mask_q[rtrn_id];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (rsp_vld_i) begin
        wr_idx_q <= wr_idx_q + 1'b1;
      end
      // pop every cycle while not empty
      if (evict_o) begin
        rd_idx_q <= rd_idx_q + 1'b1;
      end
      case ({rsp_vld_i, evict_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_vld_i) begin
      fifo_q[wr_idx_q] <= rsp_id_i;
    end
  end

  ////////////////////
  // slot table
  ////////////////////

  // evicted slot is still busy this cycle, so alloc never picks it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      slot_vld_q <= '0;
    end else begin
      if (evict_o) begin
        slot_vld_q[rtrn_id] <= 1'b0;
      end
      if (sent_i) begin
        slot_vld_q[mem_id_o] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sent_i) begin
      slot_ptr_q[mem_id_o]  <= sent_ptr_i;
      slot_mask_q[mem_id_o] <= sent_mask_i;
    end
  end

endmodule

/* design/wbuf_write_port.sv */
// store buffer input side
// matches an incoming store against live entries, picks the target
// entry (hit first, else lowest free one) and grants the store

`timescale 1ns/1ps

module wbuf_write_port (
  input  logic                                                      req_i,
  input  logic [wbuf_cfg_pkg::PLEN-1:0]                             addr_i,
  input  logic [wbuf_cfg_pkg::NUM_BYTES-1:0]                        be_i,
  input  logic [wbuf_cfg_pkg::XLEN-1:0]                             wdata_i,
  input  logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0]                       entry_valid_i,
  input  logic [wbuf_cfg_pkg::WBUF_DEPTH-1:0][wbuf_cfg_pkg::WTAG_W-1:0] entry_wtag_i,
  output logic                                                      gnt_o,
  output logic                                                      wr_en_o,
  output logic [wbuf_cfg_pkg::WBUF_PTR_W-1:0]                       wr_ptr_o,
  output logic [wbuf_cfg_pkg::WTAG_W-1:0]                           wr_wtag_o,
  output logic [wbuf_cfg_pkg::NUM_BYTES-1:0]                        wr_be_o,
  output logic [wbuf_cfg_pkg::XLEN-1:0]                             wr_data_o
);

  import wbuf_cfg_pkg::*;

  logic [WTAG_W-1:0]     req_wtag;
  logic [WBUF_DEPTH-1:0] hit;
  logic [WBUF_PTR_W-1:0] hit_ptr;
  logic [WBUF_PTR_W-1:0] free_ptr;
  logic                  full;

  // word address of the store
  assign req_wtag = addr_i[PLEN-1:BYTE_OFF_W];

  // at most one live entry holds a given word
  always_comb begin
    for (int k = 0; k < WBUF_DEPTH; k++) begin
      hit[k] = entry_valid_i[k] && (entry_wtag_i[k] == req_wtag);
    end
  end

  // lowest hit and lowest free entry, scanned downwards
  always_comb begin
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = WBUF_DEPTH - 1; k >= 0; k--) begin
      if (hit[k]) begin
        hit_ptr = WBUF_PTR_W'(k);
      end
      if (!entry_valid_i[k]) begin
        free_ptr = WBUF_PTR_W'(k);
      end
    end
  end

  assign full = &entry_valid_i;

  // a hit coalesces even when every entry is taken
  assign gnt_o     = req_i && ((|hit) || !full);
  assign wr_en_o   = gnt_o;
  assign wr_ptr_o  = (|hit) ? hit_ptr : free_ptr;
  assign wr_wtag_o = req_wtag;
  assign wr_be_o   = be_i;
  assign wr_data_o = wdata_i;

endmodule

/* design/wbuffer_top.sv */
// coalescing store buffer for a write-through data cache
// merges byte-enabled stores per word and drains dirty bytes to memory
// as aligned transactions, up to two in flight

`timescale 1ns/1ps

module wbuffer_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  // core store port
  input  logic                                req_i,
  input  logic [wbuf_cfg_pkg::PLEN-1:0]       addr_i,
  input  logic [wbuf_cfg_pkg::NUM_BYTES-1:0]  be_i,
  input  logic [wbuf_cfg_pkg::XLEN-1:0]       wdata_i,
  output logic                                gnt_o,
  // memory request
  output logic                                mem_req_o,
  input  logic                                mem_ack_i,
  output logic [wbuf_cfg_pkg::PLEN-1:0]       mem_addr_o,
  output logic [wbuf_mem_pkg::SIZE_W-1:0]     mem_size_o,
  output logic [wbuf_cfg_pkg::XLEN-1:0]       mem_wdata_o,
  output logic [wbuf_mem_pkg::TX_ID_W-1:0]    mem_id_o,
  // memory response
  input  logic                                rsp_vld_i,
  input  logic [wbuf_mem_pkg::TX_ID_W-1:0]    rsp_id_i,
  output logic                                empty_o
);

  import wbuf_cfg_pkg::*;

  logic [WBUF_DEPTH-1:0]                entry_valid;
  logic [WBUF_DEPTH-1:0][WTAG_W-1:0]    entry_wtag;
  logic [WBUF_DEPTH-1:0][XLEN-1:0]      entry_data;
  logic [WBUF_DEPTH-1:0][NUM_BYTES-1:0] sendable;
  logic                                 wr_en;
  logic [WBUF_PTR_W-1:0]                wr_ptr;
  logic [WTAG_W-1:0]                    wr_wtag;
  logic [NUM_BYTES-1:0]                 wr_be;
  logic [XLEN-1:0]                      wr_data;
  logic                                 sent;
  logic [WBUF_PTR_W-1:0]                sent_ptr;
  logic [NUM_BYTES-1:0]                 sent_mask;
  logic                                 slot_free;
  logic                                 evict;
  logic [WBUF_PTR_W-1:0]                evict_ptr;
  logic [NUM_BYTES-1:0]                 evict_mask;

  wbuf_write_port wbuf_write_port_i (
    .req_i         (req_i),
    .addr_i        (addr_i),
    .be_i          (be_i),
    .wdata_i       (wdata_i),
    .entry_valid_i (entry_valid),
    .entry_wtag_i  (entry_wtag),
    .gnt_o         (gnt_o),
    .wr_en_o       (wr_en),
    .wr_ptr_o      (wr_ptr),
    .wr_wtag_o     (wr_wtag),
    .wr_be_o       (wr_be),
    .wr_data_o     (wr_data)
  );

  wbuf_store wbuf_store_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .wr_en_i       (wr_en),
    .wr_ptr_i      (wr_ptr),
    .wr_wtag_i     (wr_wtag),
    .wr_be_i       (wr_be),
    .wr_data_i     (wr_data),
    .sent_i        (sent),
    .sent_ptr_i    (sent_ptr),
    .sent_mask_i   (sent_mask),
    .evict_i       (evict),
    .evict_ptr_i   (evict_ptr),
    .evict_mask_i  (evict_mask),
    .entry_valid_o (entry_valid),
    .entry_wtag_o  (entry_wtag),
    .entry_data_o  (entry_data),
    .sendable_o    (sendable),
    .empty_o       (empty_o)
  );

  wbuf_tx_issue wbuf_tx_issue_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .sendable_i    (sendable),
    .entry_wtag_i  (entry_wtag),
    .entry_data_i  (entry_data),
    .slot_free_i   (slot_free),
    .mem_ack_i     (mem_ack_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_size_o    (mem_size_o),
    .mem_wdata_o   (mem_wdata_o),
    .sent_o        (sent),
    .sent_ptr_o    (sent_ptr),
    .sent_mask_o   (sent_mask)
  );

  wbuf_tx_track wbuf_tx_track_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .sent_i        (sent),
    .sent_ptr_i    (sent_ptr),
    .sent_mask_i   (sent_mask),
    .rsp_vld_i     (rsp_vld_i),
    .rsp_id_i      (rsp_id_i),
    .mem_id_o      (mem_id_o),
    .slot_free_o   (slot_free),
    .evict_o       (evict),
    .evict_ptr_o   (evict_ptr),
    .evict_mask_o  (evict_mask)
  );

endmodule

/* sources.f */
design/wbuf_cfg_pkg.sv
design/wbuf_mem_pkg.sv
design/wbuf_write_port.sv
design/wbuf_store.sv
design/wbuf_tx_issue.sv
design/wbuf_tx_track.sv
design/wbuffer_top.sv
tb/wbuffer_tb.sv

/* tb/wbuffer_tb.sv */
// testbench for the coalescing store buffer
// applies a table of stores, models a memory that acks and answers out of
// order, and checks every transaction against the byte-level rules

`timescale 1ns/1ps

module wbuffer_tb;

  import wbuf_cfg_pkg::*;
  import wbuf_mem_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int NUM_ROWS        = 14;
  localparam int WATCHDOG_CYCLES = 200 * NUM_ROWS;
  localparam int GNT_TIMEOUT     = 100;
  // modelled memory covers the low 32 KiB
  localparam int MEM_BYTES       = 32768;
  localparam int NUM_WORDS       = MEM_BYTES / NUM_BYTES;

  logic                 clk_i;
  logic                 rst_i;
  logic                 req_i;
  logic [PLEN-1:0]      addr_i;
  logic [NUM_BYTES-1:0] be_i;
  logic [XLEN-1:0]      wdata_i;
  logic                 gnt_o;
  logic                 mem_req_o;
  logic                 mem_ack_i;
  logic [PLEN-1:0]      mem_addr_o;
  logic [SIZE_W-1:0]    mem_size_o;
  logic [XLEN-1:0]      mem_wdata_o;
  logic [TX_ID_W-1:0]   mem_id_o;
  logic                 rsp_vld_i;
  logic [TX_ID_W-1:0]   rsp_id_i;
  logic                 empty_o;

  // stimulus table
  // hold keeps acks off and stall expects no grant at first
  logic [PLEN-1:0]      row_addr  [NUM_ROWS];
  logic [NUM_BYTES-1:0] row_be    [NUM_ROWS];
  logic [XLEN-1:0]      row_data  [NUM_ROWS];
  logic                 row_hold  [NUM_ROWS];
  logic                 row_stall [NUM_ROWS];

  // memory as written by the DUT, and the last value stored per byte
  logic [7:0]           mem_bytes  [MEM_BYTES];
  logic [7:0]           ref_bytes  [MEM_BYTES];
  // per word bytes still owed to memory, and words with a transaction out
  logic [NUM_BYTES-1:0] dirty_mask [NUM_WORDS];
  logic                 busy_word  [NUM_WORDS];
  logic                 touched    [NUM_WORDS];
  int                   word_list  [$];
  // acked transactions waiting for their response
  logic [TX_ID_W-1:0]   fl_id      [$];
  int                   fl_word    [$];
  logic                 hold_ack;
  logic                 hold_now;
  logic [31:0]          rng;
  int                   ack_wait;

  wbuffer_top wbuffer_top_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .addr_i      (addr_i),
    .be_i        (be_i),
    .wdata_i     (wdata_i),
    .gnt_o       (gnt_o),
    .mem_req_o   (mem_req_o),
    .mem_ack_i   (mem_ack_i),
    .mem_addr_o  (mem_addr_o),
    .mem_size_o  (mem_size_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_id_o    (mem_id_o),
    .rsp_vld_i   (rsp_vld_i),
    .rsp_id_i    (rsp_id_i),
    .empty_o     (empty_o)
  );

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // initial byte content mixing every address bit
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a) ^ 8'(a >> 8);
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0d ns: %s, got %b expected %b",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_size(input string what, input logic [SIZE_W-1:0] got,
                            input logic [SIZE_W-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0d ns: %s, got size code %0d expected %0d",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_data(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0d ns: %s, got %h expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic set_row(input int r, input logic [PLEN-1:0] a, input logic [7:0] be,
                         input logic [XLEN-1:0] d, input logic hold, input logic stall);
    row_addr[r]  = a;
    row_be[r]    = be;
    row_data[r]  = d;
    row_hold[r]  = hold;
    row_stall[r] = stall;
  endtask

  task automatic load_table();
    // four distinct words with memory stalled
    // the last one has bytes 0, 3, 4 and 5
    set_row(0,  32'h0000_1000, 8'hff, 64'h0706_0504_0302_0100, 1'b1, 1'b0);
    set_row(1,  32'h0000_1008, 8'h0f, 64'h1f1e_1d1c_1b1a_1918, 1'b1, 1'b0);
    set_row(2,  32'h0000_1010, 8'hf0, 64'h2726_2524_2322_2120, 1'b1, 1'b0);
    set_row(3,  32'h0000_1018, 8'h39, 64'h3736_3534_3332_3130, 1'b1, 1'b0);
    // coalesces into the word of row 1 although the buffer is full
    set_row(4,  32'h0000_100c, 8'hf0, 64'h4746_4544_4342_4140, 1'b1, 1'b0);
    // new word that waits until traffic resumes
    set_row(5,  32'h0000_2000, 8'h81, 64'h5756_5554_5352_5150, 1'b0, 1'b1);
    // back to back rewrites that may land while in flight
    set_row(6,  32'h0000_2000, 8'h01, 64'h0000_0000_0000_00a1, 1'b0, 1'b0);
    set_row(7,  32'h0000_2000, 8'h81, 64'hb200_0000_0000_00a2, 1'b0, 1'b0);
    set_row(8,  32'h0000_3004, 8'hf0, 64'h6766_6564_6362_6160, 1'b0, 1'b0);
    set_row(9,  32'h0000_3000, 8'h3c, 64'h7776_7574_7372_7170, 1'b0, 1'b0);
    set_row(10, 32'h0000_1018, 8'h06, 64'h8786_8584_8382_8180, 1'b0, 1'b0);
    set_row(11, 32'h0000_4000, 8'hff, 64'h9796_9594_9392_9190, 1'b0, 1'b0);
    set_row(12, 32'h0000_4000, 8'h10, 64'ha7a6_a5a4_a3a2_a1a0, 1'b0, 1'b0);
    set_row(13, 32'h0000_5002, 8'h04, 64'hb7b6_b5b4_b3b2_b1b0, 1'b0, 1'b0);
  endtask

  ////////////////////
  // core side
  ////////////////////

  // accepted store updates the expected bytes and what is owed to memory
  task automatic record_store(input int r);
    int widx;
    widx = int'(row_addr[r] >> BYTE_OFF_W);
    if (!touched[widx]) begin
      touched[widx] = 1'b1;
      word_list.push_back(widx);
    end
    for (int b = 0; b < NUM_BYTES; b++) begin
      if (row_be[r][b]) begin
        ref_bytes[widx*NUM_BYTES + b] = row_data[r][b*8 +: 8];
        dirty_mask[widx][b] = 1'b1;
      end
    end
  endtask

  // starts a little after a rising edge and returns at the same point
  task automatic apply_row(input int r);
    int waited;
    addr_i  = row_addr[r];
    be_i    = row_be[r];
    wdata_i = row_data[r];
    req_i   = 1'b1;
    if (row_stall[r]) begin
      // all entries hold other words and memory is stalled
      repeat (4) begin
        @(negedge clk_i);
        check_flag($sformatf("grant of row %0d to a new word while full", r), gnt_o, 1'b0);
      end
      @(posedge clk_i);
      #2;
    end
    hold_ack = row_hold[r];
    @(negedge clk_i);
    if (row_hold[r]) begin
      check_flag($sformatf("grant of row %0d while memory is stalled", r), gnt_o, 1'b1);
    end
    waited = 0;
    while (!gnt_o) begin
      if (waited == GNT_TIMEOUT) begin
        report_failure($sformatf("store of row %0d was never granted", r));
      end
      waited++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2;
    record_store(r);
  endtask

  ////////////////////
  // memory side
  ////////////////////

  // check the transaction acked this cycle against the dirty bytes
  task automatic capture_request();
    mem_addr_u            a;
    int                   widx;
    int                   off;
    int                   exp_off;
    int                   n;
    logic [NUM_BYTES-1:0] dm;
    logic [SIZE_W-1:0]    exp_size;
    logic [XLEN-1:0]      exp_data;
    a.flat = mem_addr_o;
    check_flag($sformatf("address %h inside the modelled memory", a.flat),
               a.flat < MEM_BYTES, 1'b1);
    widx = int'(a.split.wtag);
    off  = int'(a.split.off);
    dm   = dirty_mask[widx];
    check_flag($sformatf("word of %h has bytes to send", a.flat), |dm, 1'b1);
    check_flag($sformatf("word of %h already in flight", a.flat), busy_word[widx], 1'b0);
    check_flag("room for another transaction in flight", fl_id.size() < MAX_TX, 1'b1);
    for (int i = 0; i < fl_id.size(); i++) begin
      check_flag($sformatf("ID %0d reused before its response", mem_id_o),
                 fl_id[i] == mem_id_o, 1'b0);
    end
    // lowest dirty byte, then the largest aligned chunk fully dirty
    exp_off = 0;
    for (int b = NUM_BYTES - 1; b >= 0; b--) begin
      if (dm[b]) begin
        exp_off = b;
      end
    end
    exp_size = SIZE_BYTE;
    for (int s = 1; s < 4; s++) begin
      n = 1 << s;
      if ((exp_off % n == 0) && (((dm >> exp_off) & ((1 << n) - 1)) == (1 << n) - 1)) begin
        exp_size = SIZE_W'(s);
      end
    end
    check_flag($sformatf("offset of %h is the lowest dirty byte %0d", a.flat, exp_off),
               off == exp_off, 1'b1);
    check_flag($sformatf("request at %h aligned to its size", a.flat),
               off % (1 << mem_size_o) == 0, 1'b1);
    check_size($sformatf("size of request at %h", a.flat), mem_size_o, exp_size);
    // chunk repeated over all lanes
    n = 1 << exp_size;
    for (int j = 0; j < NUM_BYTES; j++) begin
      exp_data[j*8 +: 8] = ref_bytes[widx*NUM_BYTES + exp_off + (j % n)];
    end
    check_data($sformatf("write data of request at %h", a.flat), mem_wdata_o, exp_data);
    for (int k = 0; k < n; k++) begin
      mem_bytes[int'(a.flat) + k] = mem_wdata_o[(off + k)*8 +: 8];
      dm[off + k] = 1'b0;
    end
    dirty_mask[widx] = dm;
    busy_word[widx]  = 1'b1;
    fl_id.push_back(mem_id_o);
    fl_word.push_back(widx);
  endtask

  // acks after a random delay and responses in random order
  task automatic drive_memory_inputs();
    int pick;
    mem_ack_i = 1'b0;
    rsp_vld_i = 1'b0;
    if (!hold_now && mem_req_o) begin
      if (ack_wait == 0) begin
        mem_ack_i = 1'b1;
        rng       = xorshift(rng);
        ack_wait  = int'(rng[1:0]);
      end else begin
        ack_wait--;
      end
    end
    if (fl_id.size() > 0) begin
      rng = xorshift(rng);
      if (rng[1:0] == 2'b00) begin
        pick      = int'(rng[15:8]) % fl_id.size();
        rsp_vld_i = 1'b1;
        rsp_id_i  = fl_id[pick];
        busy_word[fl_word[pick]] = 1'b0;
        fl_id.delete(pick);
        fl_word.delete(pick);
      end
    end
  endtask

  task automatic compare_final_memory();
    logic [XLEN-1:0] got;
    logic [XLEN-1:0] exp;
    int              widx;
    for (int i = 0; i < word_list.size(); i++) begin
      widx = word_list[i];
      for (int b = 0; b < NUM_BYTES; b++) begin
        got[b*8 +: 8] = mem_bytes[widx*NUM_BYTES + b];
        exp[b*8 +: 8] = ref_bytes[widx*NUM_BYTES + b];
      end
      check_data($sformatf("memory word at %h after drain", widx*NUM_BYTES), got, exp);
      check_flag($sformatf("word at %h fully sent", widx*NUM_BYTES),
                 dirty_mask[widx] == '0, 1'b1);
    end
  endtask

  ////////////////////
  // processes
  ////////////////////

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  // memory responder sampling at the falling edge and driving after the rising one
  initial begin
    mem_ack_i = 1'b0;
    rsp_vld_i = 1'b0;
    rsp_id_i  = '0;
    rng       = 32'heabb;
    ack_wait  = 0;
    forever begin
      @(negedge clk_i);
      hold_now = hold_ack;
      if (mem_req_o && mem_ack_i) begin
        capture_request();
      end
      @(posedge clk_i);
      #2;
      drive_memory_inputs();
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("watchdog expired before the buffer drained");
  end

  initial begin
    rst_i    = 1'b1;
    req_i    = 1'b0;
    addr_i   = '0;
    be_i     = '0;
    wdata_i  = '0;
    hold_ack = 1'b0;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem_bytes[a] = fill_byte(a);
      ref_bytes[a] = fill_byte(a);
    end
    for (int w = 0; w < NUM_WORDS; w++) begin
      dirty_mask[w] = '0;
      busy_word[w]  = 1'b0;
      touched[w]    = 1'b0;
    end
    load_table();
    repeat (16) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_flag("grant after reset", gnt_o, 1'b0);
    check_flag("memory request after reset", mem_req_o, 1'b0);
    check_flag("empty after reset", empty_o, 1'b1);
    @(posedge clk_i);
    #2;
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
    end
    req_i = 1'b0;
    // wait for the buffer to drain
    @(negedge clk_i);
    while (!empty_o) begin
      @(negedge clk_i);
    end
    check_flag("memory request once empty", mem_req_o, 1'b0);
    check_flag("all responses returned once empty", fl_id.size() == 0, 1'b1);
    compare_final_memory();
    $display("Finished with no errors");
    $finish;
  end

endmodule
